/* src.f */
hw/mem_bus_pkg.sv
hw/mem_shell_cfg_pkg.sv
hw/avmm_if.sv
hw/reset_sync.sv
hw/avmm_port_mux.sv
hw/avmm_pipe_bridge.sv
hw/mem_shell_top.sv
tests/mem_shell_tb.sv

/* tests/mem_shell_tb.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * Memory shell testbench
 * Drives the AFU ports of mem_shell_top, answers the memory port with a
 * randomized Avalon-MM memory model and checks reset behavior, read data,
 * command order and round-robin fairness.
 */
module mem_shell_tb
   import mem_bus_pkg::*, mem_shell_cfg_pkg::*;
();

   localparam int NUM_PORTS  = NUM_PORTS_DEFAULT;
   localparam int RST_CYCLES = 2;
   localparam int N_RAND     = 40;
   localparam int N_FAIR     = 12;
   localparam int TOTAL_TXNS = 3 + NUM_PORTS * (N_RAND + N_FAIR);
   localparam int CMD_W      = 1 + ADDR_WIDTH + DATA_WIDTH + BYTEEN_WIDTH;
   localparam logic [31:0] SEED = 32'h4253_1743;

   localparam int ERR_CTRL = 0;
   localparam int ERR_DATA = 1;
   localparam int ERR_CMD  = 2;
   localparam int ERR_FAIR = 3;

   logic                    Clk_100;
   logic                    rst;
   logic    [NUM_PORTS-1:0] afu_read;
   logic    [NUM_PORTS-1:0] afu_write;
   addr_t   [NUM_PORTS-1:0] afu_address;
   data_t   [NUM_PORTS-1:0] afu_writedata;
   byteen_t [NUM_PORTS-1:0] afu_byteenable;
   logic    [NUM_PORTS-1:0] afu_waitrequest;
   data_t   [NUM_PORTS-1:0] afu_readdata;
   logic    [NUM_PORTS-1:0] afu_readdatavalid;
   addr_t                   mem_address;
   data_t                   mem_writedata;
   byteen_t                 mem_byteenable;
   logic                    mem_read;
   logic                    mem_write;
   logic                    mem_waitrequest;
   data_t                   mem_readdata;
   logic                    mem_readdatavalid;

   int                   cyc = 0;
   int                   err_count [4];
   int                   reads_issued [NUM_PORTS];
   int                   reads_done [NUM_PORTS];
   int                   since_grant [NUM_PORTS];
   int                   reads_open;
   int                   last_due;
   logic [31:0]          mem_rng;
   logic                 rand_go;
   logic                 fair_go;
   logic                 fair_phase;
   logic [NUM_PORTS-1:0] rand_done;
   logic [NUM_PORTS-1:0] fair_done;

   // Expected state follows the commands the AFU ports hand over
   data_t             ref_mem [addr_t];
   data_t             exp_q [NUM_PORTS][$];
   logic [CMD_W-1:0]  cmd_q [$];
   // Memory model state follows the commands the memory port takes
   data_t             model_mem [addr_t];
   data_t             resp_data [$];
   int                resp_due [$];

   mem_shell_top #(
      .NUM_PORTS           (NUM_PORTS),
      .TRACKER_DEPTH       (TRACKER_DEPTH_DEFAULT),
      .READDATA_PIPE_DEPTH (READDATA_PIPE_DEPTH_DEFAULT),
      .SYNC_LEN            (SYNC_LEN_DEFAULT)
   ) mem_shell_top_i (
      .Clk_100           (Clk_100),
      .rst               (rst),
      .afu_read          (afu_read),
      .afu_write         (afu_write),
      .afu_address       (afu_address),
      .afu_writedata     (afu_writedata),
      .afu_byteenable    (afu_byteenable),
      .afu_waitrequest   (afu_waitrequest),
      .afu_readdata      (afu_readdata),
      .afu_readdatavalid (afu_readdatavalid),
      .mem_address       (mem_address),
      .mem_writedata     (mem_writedata),
      .mem_byteenable    (mem_byteenable),
      .mem_read          (mem_read),
      .mem_write         (mem_write),
      .mem_waitrequest   (mem_waitrequest),
      .mem_readdata      (mem_readdata),
      .mem_readdatavalid (mem_readdatavalid)
   );

   // ==================================================
   // Reference functions
   // ==================================================

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Contents of a word that was never written
   function automatic data_t mem_init(input addr_t a);
      logic [31:0] lo;
      logic [31:0] hi;
      lo = xorshift32({16'hA5C3, a} ^ SEED);
      hi = xorshift32(lo ^ {a, ~a});
      return {hi, lo};
   endfunction

   function automatic data_t merge_word(input data_t old_w, input data_t new_w,
                                        input byteen_t be);
      data_t w;
      w = old_w;
      for (int b = 0; b < BYTEEN_WIDTH; b++)
         if (be[b])
            w[8*b +: 8] = new_w[8*b +: 8];
      return w;
   endfunction

   function automatic data_t ref_word(input addr_t a);
      return ref_mem.exists(a) ? ref_mem[a] : mem_init(a);
   endfunction

   function automatic data_t model_word(input addr_t a);
      return model_mem.exists(a) ? model_mem[a] : mem_init(a);
   endfunction

   // Write data and byte enables do not matter for reads
   function automatic logic [CMD_W-1:0] cmd_key(input logic wr, input addr_t a,
                                                input data_t d, input byteen_t be);
      return wr ? {wr, a, d, be} : {wr, a, {DATA_WIDTH{1'b0}}, {BYTEEN_WIDTH{1'b0}}};
   endfunction

   task automatic compare_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp, input int kind);
      assert (got === exp)
      else
      begin
         $display("CHECK FAILED at %0t: %s = %0h, expected %0h", $time, name, got, exp);
         err_count[kind]++;
      end
   endtask

   // ==================================================
   // Stimulus tasks
   // ==================================================

   // Present one command and hold it until the port accepts it
   task automatic issue_cmd(input port_id_t p, input logic wr, input addr_t a,
                            input data_t d, input byteen_t be);
      afu_read[p]       = !wr;
      afu_write[p]      = wr;
      afu_address[p]    = a;
      afu_writedata[p]  = d;
      afu_byteenable[p] = be;
      @(negedge Clk_100);
      while (afu_waitrequest[p])
         @(negedge Clk_100);
      @(posedge Clk_100);
      #1;
      afu_read[p]  = 1'b0;
      afu_write[p] = 1'b0;
   endtask

   task automatic run_random(input port_id_t p, input int n);
      logic [31:0] r;
      r = xorshift32(SEED + 32'(p) + 32'd1);
      for (int i = 0; i < n; i++)
      begin
         r = xorshift32(r);
         // Sixteen shared words so ports hit each other's data
         issue_cmd(p, r[0], 16'h0100 + addr_t'(r[7:4]), {r, xorshift32(r ^ 32'h1)},
                   byteen_t'(r[15:8]));
         r = xorshift32(r);
         if (r[1:0] != 2'd0)
         begin
            repeat (r[1:0]) @(posedge Clk_100);
            #1;
         end
      end
   endtask

   task automatic run_fair(input port_id_t p, input int n);
      for (int i = 0; i < n; i++)
         issue_cmd(p, 1'b1, 16'h0300 + addr_t'(i), {32'(p), 32'(i)}, '1);
   endtask

   task automatic drain_reads();
      while (reads_open != 0)
         @(posedge Clk_100);
      #1;
   endtask

   for (genvar g = 0; g < NUM_PORTS; g++)
   begin : g_drv
      initial
      begin
         rand_done[g] = 1'b0;
         fair_done[g] = 1'b0;
         wait (rand_go);
         run_random(port_id_t'(g), N_RAND);
         rand_done[g] = 1'b1;
         wait (fair_go);
         run_fair(port_id_t'(g), N_FAIR);
         fair_done[g] = 1'b1;
      end
   end

   // ==================================================
   // Clock, memory model and watchdog
   // ==================================================

   initial
   begin
      Clk_100 = 1'b0;
      forever #5 Clk_100 = ~Clk_100;
   end

   always @(posedge Clk_100)
      cyc <= cyc + 1;

   // Random stalls and in-order read responses once they fall due
   always @(posedge Clk_100)
   begin
      #1;
      mem_rng         = xorshift32(mem_rng);
      mem_waitrequest = (mem_rng[2:0] < 3'd3);
      if (resp_due.size() != 0 && resp_due[0] <= cyc)
      begin
         mem_readdatavalid = 1'b1;
         mem_readdata      = resp_data.pop_front();
         void'(resp_due.pop_front());
      end
      else
         mem_readdatavalid = 1'b0;
   end

   initial
   begin
      repeat (TOTAL_TXNS * 40) @(posedge Clk_100);
      $display("Timeout: the run did not finish within %0d cycles", TOTAL_TXNS * 40);
      $display("** FAIL **");
      $finish;
   end

   // ==================================================
   // Monitors and checkers
   // ==================================================

   always @(negedge Clk_100)
   begin : check_control
      if (cyc > 0 && cyc <= RST_CYCLES + SYNC_LEN_DEFAULT)
      begin
         compare_value("afu_waitrequest", afu_waitrequest, {NUM_PORTS{1'b1}}, ERR_CTRL);
         compare_value("mem_read", mem_read, 1'b0, ERR_CTRL);
         compare_value("mem_write", mem_write, 1'b0, ERR_CTRL);
         compare_value("afu_readdatavalid", afu_readdatavalid, '0, ERR_CTRL);
      end
      else if (cyc > RST_CYCLES + SYNC_LEN_DEFAULT)
      begin
         for (int p = 0; p < NUM_PORTS; p++)
            if (!afu_read[p] && !afu_write[p] && afu_waitrequest[p])
               assert ((afu_read | afu_write) != '0)
               else
               begin
                  $display("Idle port %0d stalled at %0t with no other port requesting",
                           p, $time);
                  err_count[ERR_CTRL]++;
               end
      end
   end

   always @(negedge Clk_100)
   begin : track_commands
      int due;
      for (int p = 0; p < NUM_PORTS; p++)
         if ((afu_read[p] || afu_write[p]) && !afu_waitrequest[p])
         begin
            cmd_q.push_back(cmd_key(afu_write[p], afu_address[p], afu_writedata[p],
                                    afu_byteenable[p]));
            if (afu_write[p])
               ref_mem[afu_address[p]] = merge_word(ref_word(afu_address[p]),
                                                    afu_writedata[p], afu_byteenable[p]);
            else
            begin
               exp_q[p].push_back(ref_word(afu_address[p]));
               reads_issued[p]++;
               reads_open++;
            end
            // Fairness only means something while every port asks
            if (fair_phase && (afu_read | afu_write) == '1)
               for (int q = 0; q < NUM_PORTS; q++)
               begin
                  since_grant[q] = (q == p) ? 0 : since_grant[q] + 1;
                  assert (since_grant[q] < NUM_PORTS)
                  else
                  begin
                     $display("Port %0d was passed over %0d times in a row at %0t",
                              q, since_grant[q], $time);
                     err_count[ERR_FAIR]++;
                  end
               end
         end
      if ((mem_read || mem_write) && !mem_waitrequest)
      begin
         assert (cmd_q.size() != 0)
         else
         begin
            $display("Memory took a command at %0t that no AFU port issued", $time);
            err_count[ERR_CMD]++;
         end
         if (cmd_q.size() != 0)
            compare_value("mem_write/mem_address/mem_writedata/mem_byteenable",
                          cmd_key(mem_write, mem_address, mem_writedata, mem_byteenable),
                          cmd_q.pop_front(), ERR_CMD);
         if (mem_write)
            model_mem[mem_address] = merge_word(model_word(mem_address), mem_writedata,
                                                mem_byteenable);
         else
         begin
            // Answer 1 to 4 cycles after the accepting edge and never out of order
            mem_rng = xorshift32(mem_rng);
            due     = cyc + 2 + int'(mem_rng[1:0]);
            if (due <= last_due)
               due = last_due + 1;
            last_due = due;
            resp_data.push_back(model_word(mem_address));
            resp_due.push_back(due);
         end
      end
   end

   always @(negedge Clk_100)
   begin : check_responses
      for (int p = 0; p < NUM_PORTS; p++)
         if (afu_readdatavalid[p])
         begin
            reads_done[p]++;
            assert (exp_q[p].size() != 0)
            else
            begin
               $display("Port %0d got a read response at %0t with no read outstanding",
                        p, $time);
               err_count[ERR_DATA]++;
            end
            if (exp_q[p].size() != 0)
            begin
               compare_value($sformatf("afu_readdata[%0d]", p), afu_readdata[p],
                             exp_q[p].pop_front(), ERR_DATA);
               reads_open--;
            end
         end
   end

   // ==================================================
   // Test sequence
   // ==================================================

   initial
   begin
      rst               = 1'b1;
      afu_read          = '0;
      afu_write         = '0;
      afu_address       = '0;
      afu_writedata     = '0;
      afu_byteenable    = '0;
      mem_waitrequest   = 1'b0;
      mem_readdata      = '0;
      mem_readdatavalid = 1'b0;
      mem_rng           = SEED;
      rand_go           = 1'b0;
      fair_go           = 1'b0;
      fair_phase        = 1'b0;
      reads_open        = 0;
      last_due          = 0;
      for (int k = 0; k < 4; k++)
         err_count[k] = 0;
      for (int p = 0; p < NUM_PORTS; p++)
      begin
         reads_issued[p] = 0;
         reads_done[p]   = 0;
         since_grant[p]  = 0;
      end

      repeat (RST_CYCLES) @(posedge Clk_100);
      #1;
      rst = 1'b0;
      repeat (4) @(posedge Clk_100);
      #1;

      // Unwritten word and then a partial write read back from another port
      issue_cmd(0, 1'b0, 16'h0123, '0, '0);
      drain_reads();
      issue_cmd(1, 1'b1, 16'h0200, 64'h1122_3344_5566_7788, 8'b0011_0101);
      issue_cmd(2, 1'b0, 16'h0200, '0, '0);
      drain_reads();

      // All ports at once with random traffic
      rand_go = 1'b1;
      wait (rand_done == '1);
      drain_reads();

      // Back-to-back writes from every port
      fair_phase = 1'b1;
      fair_go    = 1'b1;
      wait (fair_done == '1);
      drain_reads();
      // The last write still sits in the bridge until the memory takes it
      @(negedge Clk_100);
      while (mem_read || mem_write)
         @(negedge Clk_100);

      for (int p = 0; p < NUM_PORTS; p++)
         assert (reads_done[p] == reads_issued[p])
         else
         begin
            $display("Port %0d issued %0d reads but got %0d responses",
                     p, reads_issued[p], reads_done[p]);
            err_count[ERR_DATA]++;
         end
      assert (cmd_q.size() == 0)
      else
      begin
         $display("%0d accepted commands never reached the memory port", cmd_q.size());
         err_count[ERR_CMD]++;
      end

      $display("Errors: control %0d, read data %0d, command order %0d, fairness %0d",
               err_count[ERR_CTRL], err_count[ERR_DATA], err_count[ERR_CMD],
               err_count[ERR_FAIR]);
      if (err_count[ERR_CTRL] + err_count[ERR_DATA] + err_count[ERR_CMD]
          + err_count[ERR_FAIR] == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

/* hw/mem_shell_top.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * Local-memory shell
 * Several AFU ports share one memory bank. The port mux arbitrates them
 * onto a shared Avalon-MM stream, and a pipeline bridge drives the bank.
 * The bank reset is synchronized before any of this logic sees it.
 */
module mem_shell_top
   import mem_bus_pkg::*, mem_shell_cfg_pkg::*;
#(
   parameter int NUM_PORTS           = NUM_PORTS_DEFAULT,
   parameter int TRACKER_DEPTH       = TRACKER_DEPTH_DEFAULT,
   parameter int READDATA_PIPE_DEPTH = READDATA_PIPE_DEPTH_DEFAULT,
   parameter int SYNC_LEN            = SYNC_LEN_DEFAULT
) (
   input  logic                    Clk_100,
   input  logic                    rst,

   // AFU ports, one array element per port
   input  logic    [NUM_PORTS-1:0] afu_read,
   input  logic    [NUM_PORTS-1:0] afu_write,
   input  addr_t   [NUM_PORTS-1:0] afu_address,
   input  data_t   [NUM_PORTS-1:0] afu_writedata,
   input  byteen_t [NUM_PORTS-1:0] afu_byteenable,
   output logic    [NUM_PORTS-1:0] afu_waitrequest,
   output data_t   [NUM_PORTS-1:0] afu_readdata,
   output logic    [NUM_PORTS-1:0] afu_readdatavalid,

   // Memory bank
   output addr_t                   mem_address,
   output data_t                   mem_writedata,
   output byteen_t                 mem_byteenable,
   output logic                    mem_read,
   output logic                    mem_write,
   input  logic                    mem_waitrequest,
   input  data_t                   mem_readdata,
   input  logic                    mem_readdatavalid
);

   logic bank_rst;

   avmm_if shared_if ();
   avmm_if mem_if ();

   reset_sync #(
      .SYNC_LEN (SYNC_LEN)
   ) reset_sync_i (
      .Clk_100  (Clk_100),
      .rst      (rst),
      .bank_rst (bank_rst)
   );

   avmm_port_mux #(
      .NUM_PORTS     (NUM_PORTS),
      .TRACKER_DEPTH (TRACKER_DEPTH)
   ) avmm_port_mux_i (
      .Clk_100           (Clk_100),
      .bank_rst          (bank_rst),
      .afu_read          (afu_read),
      .afu_write         (afu_write),
      .afu_address       (afu_address),
      .afu_writedata     (afu_writedata),
      .afu_byteenable    (afu_byteenable),
      .afu_waitrequest   (afu_waitrequest),
      .afu_readdata      (afu_readdata),
      .afu_readdatavalid (afu_readdatavalid),
      .shared            (shared_if)
   );

   avmm_pipe_bridge #(
      .READDATA_PIPE_DEPTH (READDATA_PIPE_DEPTH)
   ) avmm_pipe_bridge_i (
      .Clk_100  (Clk_100),
      .bank_rst (bank_rst),
      .up       (shared_if),
      .down     (mem_if)
   );

   // Memory side of the bridge onto the bank pins
   assign mem_address    = mem_if.address;
   assign mem_writedata  = mem_if.writedata;
   assign mem_byteenable = mem_if.byteenable;
   assign mem_read       = mem_if.read;
   assign mem_write      = mem_if.write;

   assign mem_if.waitrequest   = mem_waitrequest;
   assign mem_if.readdata      = mem_readdata;
   assign mem_if.readdatavalid = mem_readdatavalid;

endmodule

`default_nettype wire

/* hw/avmm_pipe_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * Avalon-MM pipeline bridge
 * A one-entry command register with waitrequest back-pressure toward
 * the memory port, and a fixed-length pipe for the read response.
 */
module avmm_pipe_bridge
   import mem_bus_pkg::*;
#(
   parameter int READDATA_PIPE_DEPTH = 2
) (
   input  logic  Clk_100,
   input  logic  bank_rst,
   avmm_if.agent up,
   avmm_if.host  down
);

   logic    cmd_read;
   logic    cmd_write;
   addr_t   cmd_address;
   data_t   cmd_writedata;
   byteen_t cmd_byteenable;
   logic    cmd_full;
   logic    up_accept;
   logic    down_accept;

   logic [READDATA_PIPE_DEPTH-1:0] rd_valid_pipe;
   data_t                          rd_data_pipe [READDATA_PIPE_DEPTH];

   // ==================================================
   // Command stage
   // ==================================================

   assign cmd_full    = cmd_read | cmd_write;
   assign down_accept = cmd_full & !down.waitrequest;
   // A new command may enter in the cycle the old one leaves
   assign up.waitrequest = cmd_full & !down_accept;
   assign up_accept      = (up.read | up.write) & !up.waitrequest;

   always_ff @(posedge Clk_100)
   begin
      if (bank_rst)
      begin
         cmd_read  <= 1'b0;
         cmd_write <= 1'b0;
      end
      else if (up_accept)
      begin
         cmd_read  <= up.read;
         cmd_write <= up.write;
      end
      else if (down_accept)
      begin
         cmd_read  <= 1'b0;
         cmd_write <= 1'b0;
      end
   end

   always_ff @(posedge Clk_100)
   begin
      if (up_accept)
      begin
         cmd_address    <= up.address;
         cmd_writedata  <= up.writedata;
         cmd_byteenable <= up.byteenable;
      end
   end

   assign down.read       = cmd_read;
   assign down.write      = cmd_write;
   assign down.address    = cmd_address;
   assign down.writedata  = cmd_writedata;
   assign down.byteenable = cmd_byteenable;

   // ==================================================
   // Read-data pipe
   // ==================================================

   always_ff @(posedge Clk_100)
   begin
      if (bank_rst)
         rd_valid_pipe <= '0;
      else
      begin
         rd_valid_pipe[0] <= down.readdatavalid;
         for (int i = 1; i < READDATA_PIPE_DEPTH; i++)
            rd_valid_pipe[i] <= rd_valid_pipe[i-1];
      end
   end

   always_ff @(posedge Clk_100)
   begin
      rd_data_pipe[0] <= down.readdata;
      for (int i = 1; i < READDATA_PIPE_DEPTH; i++)
         rd_data_pipe[i] <= rd_data_pipe[i-1];
   end

   assign up.readdatavalid = rd_valid_pipe[READDATA_PIPE_DEPTH-1];
   assign up.readdata      = rd_data_pipe[READDATA_PIPE_DEPTH-1];

endmodule

`default_nettype wire

/* hw/avmm_port_mux.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * AFU port multiplexer
 * Round-robin arbiter that puts one AFU port at a time on the shared
 * Avalon-MM stream. Each accepted read records its port in an in-order
 * tracker, so read responses return to the port that issued them.
 */
module avmm_port_mux
   import mem_bus_pkg::*, mem_shell_cfg_pkg::*;
#(
   parameter int NUM_PORTS     = NUM_PORTS_DEFAULT,
   parameter int TRACKER_DEPTH = TRACKER_DEPTH_DEFAULT
) (
   input  logic                    Clk_100,
   input  logic                    bank_rst,
   input  logic    [NUM_PORTS-1:0] afu_read,
   input  logic    [NUM_PORTS-1:0] afu_write,
   input  addr_t   [NUM_PORTS-1:0] afu_address,
   input  data_t   [NUM_PORTS-1:0] afu_writedata,
   input  byteen_t [NUM_PORTS-1:0] afu_byteenable,
   output logic    [NUM_PORTS-1:0] afu_waitrequest,
   output data_t   [NUM_PORTS-1:0] afu_readdata,
   output logic    [NUM_PORTS-1:0] afu_readdatavalid,
   avmm_if.host                    shared
);

   localparam int PTR_W = (TRACKER_DEPTH > 1) ? $clog2(TRACKER_DEPTH) : 1;
   localparam int CNT_W = $clog2(TRACKER_DEPTH + 1);

   arb_state_t           arb_state;
   port_id_t             last_grant;
   port_id_t             hold_port;
   logic [NUM_PORTS-1:0] eligible;
   logic                 rr_valid;
   port_id_t             rr_port;
   logic                 grant_valid;
   port_id_t             grant;
   logic                 accept;

   port_id_t             tracker_mem [TRACKER_DEPTH];
   logic [PTR_W-1:0]     wr_ptr;
   logic [PTR_W-1:0]     rd_ptr;
   logic [CNT_W-1:0]     rd_count;
   logic                 tracker_full;
   logic                 push;
   logic                 pop;
   port_id_t             head_port;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(TRACKER_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // ==================================================
   // Arbitration
   // ==================================================

   // A full tracker holds back reads, writes still go
   assign eligible = afu_write | (afu_read & {NUM_PORTS{!tracker_full}});

   // First eligible port after the last one granted
   always_comb
   begin : rr_pick
      int idx;
      rr_valid = 1'b0;
      rr_port  = '0;
      for (int i = 1; i <= NUM_PORTS; i++)
      begin
         idx = (int'(last_grant) + i) % NUM_PORTS;
         if (!rr_valid && eligible[idx])
         begin
            rr_valid = 1'b1;
            rr_port  = port_id_t'(idx);
         end
      end
   end

   // A waiting command keeps its grant until the bridge takes it
   assign grant_valid = (arb_state == ARB_HOLD) | rr_valid;
   assign grant       = (arb_state == ARB_HOLD) ? hold_port : rr_port;

   assign shared.read       = grant_valid & afu_read[grant];
   assign shared.write      = grant_valid & afu_write[grant];
   assign shared.address    = afu_address[grant];
   assign shared.writedata  = afu_writedata[grant];
   assign shared.byteenable = afu_byteenable[grant];

   assign accept = (shared.read | shared.write) & !shared.waitrequest;

   always_ff @(posedge Clk_100)
   begin
      if (bank_rst)
      begin
         arb_state  <= ARB_IDLE;
         last_grant <= port_id_t'(NUM_PORTS - 1);
         hold_port  <= '0;
      end
      else
      begin
         case (arb_state)
            ARB_IDLE:
               if (grant_valid && !accept)
               begin
                  arb_state <= ARB_HOLD;
                  hold_port <= grant;
               end
            ARB_HOLD:
               if (accept)
                  arb_state <= ARB_IDLE;
            default:
               arb_state <= ARB_IDLE;
         endcase
         if (accept)
            last_grant <= grant;
      end
   end

   // ==================================================
   // Read tracker
   // ==================================================

   assign push         = accept & shared.read;
   assign pop          = shared.readdatavalid & (rd_count != '0);
   assign tracker_full = (rd_count == CNT_W'(TRACKER_DEPTH));
   assign head_port    = tracker_mem[rd_ptr];

   always_ff @(posedge Clk_100)
   begin
      if (bank_rst)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         rd_count <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop)
            rd_ptr <= ptr_inc(rd_ptr);
         rd_count <= rd_count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   always_ff @(posedge Clk_100)
   begin
      if (push)
         tracker_mem[wr_ptr] <= grant;
   end

   // Per-port handshake and response steering
   for (genvar p = 0; p < NUM_PORTS; p++)
   begin : g_port
      assign afu_readdata[p]      = shared.readdata;
      assign afu_readdatavalid[p] = pop & (head_port == port_id_t'(p));
      // Idle ports only see a stall while some other port holds the stream
      assign afu_waitrequest[p]   = bank_rst |
         ((afu_read[p] | afu_write[p]) ? !(accept && grant == port_id_t'(p)) : grant_valid);
   end

endmodule

`default_nettype wire

/* hw/reset_sync.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * Bank reset synchronizer
 * Turns the shell reset into the memory bank reset. A chain of flops
 * shifts in zeros after rst drops, then one more register drives the
 * wide fan-out of bank_rst.
 */
module reset_sync #(
   parameter int SYNC_LEN = 2
) (
   input  logic Clk_100,
   input  logic rst,
   output logic bank_rst
);

   logic [SYNC_LEN-1:0] sync_chain;

   always_ff @(posedge Clk_100)
   begin
      if (rst)
      begin
         sync_chain <= '1;
         bank_rst   <= 1'b1;
      end
      else
      begin
         sync_chain <= sync_chain << 1;
         // Extra stage for fan-out timing
         bank_rst   <= sync_chain[SYNC_LEN-1];
      end
   end

endmodule

`default_nettype wire

/* hw/avmm_if.sv */
`timescale 1ns/1ps
`default_nettype none

/*
 * Single-word Avalon-MM link
 * Command side driven by the host, waitrequest and read response by the
 * agent. A command is taken when read or write is high and waitrequest low.
 */
interface avmm_if
   import mem_bus_pkg::*;
();

   // Command, from host to agent
   addr_t   address;
   data_t   writedata;
   byteen_t byteenable;
   logic    read;
   logic    write;

   // Flow control and read response, from agent to host
   logic    waitrequest;
   data_t   readdata;
   logic    readdatavalid;

   modport host (
      output address, writedata, byteenable, read, write,
      input  waitrequest, readdata, readdatavalid
   );

   modport agent (
      input  address, writedata, byteenable, read, write,
      output waitrequest, readdata, readdatavalid
   );

endinterface

`default_nettype wire

/* hw/mem_shell_cfg_pkg.sv */
`default_nettype none

/*
 * Memory shell configuration
 * Default port count, read tracker depth, pipe and synchronizer lengths,
 * plus the port number type and the arbiter state encoding.
 */
package mem_shell_cfg_pkg;

   localparam int NUM_PORTS_DEFAULT           = 4;
   localparam int TRACKER_DEPTH_DEFAULT       = 8;
   localparam int READDATA_PIPE_DEPTH_DEFAULT = 2;
   localparam int SYNC_LEN_DEFAULT            = 2;

   // Wide enough to number every AFU port
   typedef logic [$clog2(NUM_PORTS_DEFAULT)-1:0] port_id_t;

   // Arbiter is either free to pick or stuck on a waiting command
   typedef enum logic {ARB_IDLE, ARB_HOLD} arb_state_t;

endpackage

`default_nettype wire

/* hw/mem_bus_pkg.sv */
`default_nettype none

/*
 * Memory bus definitions
 * Word address, data and byte-enable widths of the local-memory bus,
 * with the vector types that carry them between the blocks.
 */
package mem_bus_pkg;

   // ==================================================
   // Bus widths
   // ==================================================

   // Word address, every access moves one data word
   localparam int ADDR_WIDTH   = 16;
   localparam int DATA_WIDTH   = 64;
   // One enable bit per data byte
   localparam int BYTEEN_WIDTH = DATA_WIDTH / 8;

   // ==================================================
   // Vector types
   // ==================================================

   typedef logic [ADDR_WIDTH-1:0]   addr_t;
   typedef logic [DATA_WIDTH-1:0]   data_t;
   typedef logic [BYTEEN_WIDTH-1:0] byteen_t;

endpackage

`default_nettype wire
